/* hw/ctrlPkg.sv */
//==========================================================
// control encodings shared by the pipeline stages
// blkPhase travels with each item through the pipeline
// frameState is local to the frame controller
//==========================================================

package ctrlPkg;

    // block position of an item inside its frame
    typedef enum logic [1:0] {
        phaseFirst = 2'd0,
        phaseMid   = 2'd1,
        phaseLast  = 2'd2,
        phaseOnly  = 2'd3
    } blkPhase;

    // frame tracking since reset
    typedef enum logic [1:0] {
        frmReset = 2'd0,
        frmFirst = 2'd1,
        frmRun   = 2'd2
    } frameState;

endpackage

/* hw/dotStage.sv */
//==========================================================
// weight rows and the three kernel-column dot products
// wei packs row c, element k at bits (c*BlockDepth+k)*DataWidth
// act packs element k at bits k*DataWidth, all values signed
// load weights only while no item is in the pipeline
// one register stage from actValid to dotValid
//==========================================================
`timescale 1ns/10ps

module dotStage #(
    parameter int DataWidth  = 8,
    parameter int BlockDepth = 4,
    parameter int PsumWidth  = 24,
    parameter int AddrWidth  = 4
) (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic                                               weiLoad,
    input  logic [psumPkg::NumCols*BlockDepth*DataWidth-1:0]   wei,
    input  logic                                               actValid,
    input  logic [BlockDepth*DataWidth-1:0]                    act,
    input  logic [AddrWidth-1:0]                               actAddr,
    input  logic                                               firstBlk,
    input  logic                                               lastBlk,
    output logic                                               dotValid,
    output ctrlPkg::blkPhase                                   dotPhase,
    output logic [AddrWidth-1:0]                               dotAddr,
    output logic signed [PsumWidth-1:0]                        dot0,
    output logic signed [PsumWidth-1:0]                        dot1,
    output logic signed [PsumWidth-1:0]                        dot2
);

    import psumPkg::*;
    import ctrlPkg::*;

    // weight rows, one per kernel column
    logic signed [DataWidth-1:0] weiRow [NumCols][BlockDepth];
    logic signed [PsumWidth-1:0] dotNext [NumCols];
    blkPhase                     phaseIn;

    always_ff @(posedge clk) begin
        if (weiLoad) begin
            for (int c = 0; c < NumCols; c++) begin
                for (int k = 0; k < BlockDepth; k++) begin
                    weiRow[c][k] <= wei[(c*BlockDepth + k)*DataWidth +: DataWidth];
                end
            end
        end
    end

    // signed MACs, evaluated at psum width so no product overflows
    always_comb begin
        for (int c = 0; c < NumCols; c++) begin
            dotNext[c] = '0;
            for (int k = 0; k < BlockDepth; k++) begin
                dotNext[c] = dotNext[c]
                           + $signed(act[k*DataWidth +: DataWidth]) * weiRow[c][k];
            end
        end
    end

    // block position flags to phase code
    always_comb begin
        case ({firstBlk, lastBlk})
            2'b11:   phaseIn = phaseOnly;
            2'b10:   phaseIn = phaseFirst;
            2'b01:   phaseIn = phaseLast;
            default: phaseIn = phaseMid;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dotValid <= 1'b0;
        end else begin
            dotValid <= actValid;
        end
    end

    // item payload, only qualified by dotValid
    always_ff @(posedge clk) begin
        if (actValid) begin
            dotPhase <= phaseIn;
            dotAddr  <= actAddr;
            dot0     <= dotNext[0];
            dot1     <= dotNext[1];
            dot2     <= dotNext[2];
        end
    end

endmodule

/* hw/frameCtrl.sv */
//==========================================================
// frame tracking, bank select and the pool-enable pulse
// a frame starts at a firstBlk item once the previous frame
// has shown a later-block item or 4 idle cycles have passed
// so first-block items of one frame need gaps under 4 cycles
// bankSel and poolEn update on the frame's first item edge
//==========================================================
`timescale 1ns/10ps

module frameCtrl (
    input  logic clk,
    input  logic rst_n,
    input  logic actValid,
    input  logic firstBlk,
    output logic bankSel,
    output logic poolEn
);

    import ctrlPkg::*;

    // idle cycles that close a frame made of single-block items
    localparam int GapCycles = 4;
    localparam int CntWidth  = $clog2(GapCycles + 1);

    frameState           state;
    logic [CntWidth-1:0] idleCnt;
    logic                armed;
    logic                gapSeen;
    logic                frameStart;

    assign gapSeen    = (idleCnt == CntWidth'(GapCycles));
    assign frameStart = actValid && firstBlk && (armed || gapSeen);

    // saturating idle counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idleCnt <= '0;
        end else if (actValid) begin
            idleCnt <= '0;
        end else if (!gapSeen) begin
            idleCnt <= idleCnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= frmReset;
            armed   <= 1'b1;
            bankSel <= 1'b0;
            poolEn  <= 1'b0;
        end else begin
            // no pulse for the very first frame, nothing finished yet
            poolEn <= frameStart && (state != frmReset);
            if (frameStart) begin
                armed   <= 1'b0;
                bankSel <= !bankSel;
                state   <= (state == frmReset) ? frmFirst : frmRun;
            end else if (actValid && !firstBlk) begin
                armed <= 1'b1;
            end
        end
    end

endmodule

/* hw/outputBank.sv */
//==========================================================
// cross-column sum and the two ping-pong output banks
// bankSel picks the write bank, the pool reads the other one
// the bank write happens on the edge after sumValid
// poolDat is valid one cycle after poolRdEn, zero until then
// the column sum wraps if it exceeds the psum width
//==========================================================
`timescale 1ns/10ps

module outputBank #(
    parameter int PsumWidth = 24,
    parameter int AddrWidth = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        sumValid,
    input  logic [AddrWidth-1:0]        sumAddr,
    input  logic signed [PsumWidth-1:0] colSum0,
    input  logic signed [PsumWidth-1:0] colSum1,
    input  logic signed [PsumWidth-1:0] colSum2,
    input  logic                        bankSel,
    input  logic                        poolRdEn,
    input  logic [AddrWidth-1:0]        poolAddr,
    output logic signed [PsumWidth-1:0] poolDat
);

    logic signed [PsumWidth-1:0] frameSum;
    logic [PsumWidth-1:0]        bankRd [2];
    // bank that served the last pool read
    logic                        rdBank;
    logic                        readSeen;

    // all three kernel columns for one output position
    assign frameSum = colSum0 + colSum1 + colSum2;

    //==========================================================
    // ping-pong banks
    //==========================================================
    for (genvar b = 0; b < 2; b++) begin : genBank
        logic wrSel;

        // this bank takes writes when selected, pool reads otherwise
        assign wrSel = (bankSel == 1'(b));

        psumRam #(
            .AddrWidth (AddrWidth),
            .DataWidth (PsumWidth)
        ) uBank (
            .clk    (clk),
            .wrEn   (sumValid && wrSel),
            .wrAddr (sumAddr),
            .wrData (frameSum),
            .rdEn   (poolRdEn && !wrSel),
            .rdAddr (poolAddr),
            .rdData (bankRd[b])
        );
    end

    // remember the read bank, bankSel may flip before data returns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdBank   <= 1'b0;
            readSeen <= 1'b0;
        end else if (poolRdEn) begin
            rdBank   <= !bankSel;
            readSeen <= 1'b1;
        end
    end

    // pool data mux, quiet until the first read lands
    assign poolDat = readSeen ? $signed(bankRd[rdBank]) : '0;

endmodule

/* hw/psumAccum.sv */
//==========================================================
// per-column psum accumulation across channel blocks
// SRAM read on the edge after dotValid, write one edge later
// a bypass covers the item just ahead when the address matches
// first-block items start from zero, the stored value is ignored
// totals leave on sumValid for last-block items only
//==========================================================
`timescale 1ns/10ps

module psumAccum #(
    parameter int DataWidth  = 8,
    parameter int BlockDepth = 4,
    parameter int PsumWidth  = 24,
    parameter int AddrWidth  = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        dotValid,
    input  ctrlPkg::blkPhase            dotPhase,
    input  logic [AddrWidth-1:0]        dotAddr,
    input  logic signed [PsumWidth-1:0] dot0,
    input  logic signed [PsumWidth-1:0] dot1,
    input  logic signed [PsumWidth-1:0] dot2,
    output logic                        sumValid,
    output logic [AddrWidth-1:0]        sumAddr,
    output logic signed [PsumWidth-1:0] colSum0,
    output logic signed [PsumWidth-1:0] colSum1,
    output logic signed [PsumWidth-1:0] colSum2
);

    import psumPkg::*;
    import ctrlPkg::*;

    logic signed [PsumWidth-1:0] dotVec [NumCols];
    logic signed [PsumWidth-1:0] stgDot [NumCols];
    logic signed [PsumWidth-1:0] newSum [NumCols];
    logic signed [PsumWidth-1:0] bypData [NumCols];
    logic                        stgValid;
    blkPhase                     stgPhase;
    logic [AddrWidth-1:0]        stgAddr;
    logic                        stgFirst;
    logic                        stgLast;
    logic                        bypValid;
    logic [AddrWidth-1:0]        bypAddr;
    logic                        bypHit;

    assign dotVec[0] = dot0;
    assign dotVec[1] = dot1;
    assign dotVec[2] = dot2;

    assign stgFirst = (stgPhase == phaseFirst) || (stgPhase == phaseOnly);
    assign stgLast  = (stgPhase == phaseLast)  || (stgPhase == phaseOnly);
    // previous item wrote this address on the edge our read sampled
    assign bypHit   = bypValid && (bypAddr == stgAddr);

    //==========================================================
    // column SRAMs and adders
    //==========================================================
    for (genvar c = 0; c < NumCols; c++) begin : genCol
        logic signed [PsumWidth-1:0] ramRd;
        logic signed [PsumWidth-1:0] base;

        psumRam #(
            .AddrWidth (AddrWidth),
            .DataWidth (PsumWidth)
        ) uRam (
            .clk    (clk),
            .wrEn   (stgValid),
            .wrAddr (stgAddr),
            .wrData (newSum[c]),
            .rdEn   (dotValid),
            .rdAddr (dotAddr),
            .rdData (ramRd)
        );

        // zero on the first block, else freshest stored psum
        assign base      = stgFirst ? '0 : (bypHit ? bypData[c] : ramRd);
        assign newSum[c] = base + stgDot[c];
    end

    //==========================================================
    // pipeline and bypass registers
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stgValid <= 1'b0;
            bypValid <= 1'b0;
            sumValid <= 1'b0;
        end else begin
            stgValid <= dotValid;
            bypValid <= stgValid;
            sumValid <= stgValid && stgLast;
        end
    end

    always_ff @(posedge clk) begin
        if (dotValid) begin
            stgPhase <= dotPhase;
            stgAddr  <= dotAddr;
            stgDot   <= dotVec;
        end
        // last write doubles as the downstream total
        if (stgValid) begin
            bypAddr <= stgAddr;
            bypData <= newSum;
        end
    end

    assign sumAddr = bypAddr;
    assign colSum0 = bypData[0];
    assign colSum1 = bypData[1];
    assign colSum2 = bypData[2];

endmodule

/* hw/psumBlockTop.sv */
//==========================================================
// psum block top: dot products, column accumulate, bank write
// with the frame controller beside the pipeline
// no back-pressure; items may come every cycle
// leave 4 or more idle cycles between frames
// actValid at edge N: column SRAMs at N+2, bank at N+3
//==========================================================
`timescale 1ns/10ps

module psumBlockTop #(
    parameter int DataWidth  = psumPkg::DefDataWidth,
    parameter int BlockDepth = psumPkg::DefBlockDepth,
    parameter int PsumWidth  = psumPkg::DefPsumWidth,
    parameter int AddrWidth  = psumPkg::addrWidthOf(psumPkg::DefLenPsum)
) (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             weiLoad,
    input  logic [psumPkg::NumCols*BlockDepth*DataWidth-1:0] wei,
    input  logic                                             actValid,
    input  logic [BlockDepth*DataWidth-1:0]                  act,
    input  logic [AddrWidth-1:0]                             actAddr,
    input  logic                                             firstBlk,
    input  logic                                             lastBlk,
    input  logic                                             poolRdEn,
    input  logic [AddrWidth-1:0]                             poolAddr,
    output logic                                             poolEn,
    output logic signed [PsumWidth-1:0]                      poolDat
);

    import ctrlPkg::*;

    // dot stage to accumulator
    logic                        dotValid;
    blkPhase                     dotPhase;
    logic [AddrWidth-1:0]        dotAddr;
    logic signed [PsumWidth-1:0] dot0;
    logic signed [PsumWidth-1:0] dot1;
    logic signed [PsumWidth-1:0] dot2;
    // accumulator to output banks
    logic                        sumValid;
    logic [AddrWidth-1:0]        sumAddr;
    logic signed [PsumWidth-1:0] colSum0;
    logic signed [PsumWidth-1:0] colSum1;
    logic signed [PsumWidth-1:0] colSum2;
    logic                        bankSel;

    dotStage #(
        .DataWidth (DataWidth), .BlockDepth (BlockDepth),
        .PsumWidth (PsumWidth), .AddrWidth  (AddrWidth)
    ) uDot (
        .clk, .rst_n, .weiLoad, .wei, .actValid, .act, .actAddr, .firstBlk, .lastBlk,
        .dotValid, .dotPhase, .dotAddr, .dot0, .dot1, .dot2
    );

    psumAccum #(
        .DataWidth (DataWidth), .BlockDepth (BlockDepth),
        .PsumWidth (PsumWidth), .AddrWidth  (AddrWidth)
    ) uAccum (
        .clk, .rst_n, .dotValid, .dotPhase, .dotAddr, .dot0, .dot1, .dot2,
        .sumValid, .sumAddr, .colSum0, .colSum1, .colSum2
    );

    outputBank #(
        .PsumWidth (PsumWidth),
        .AddrWidth (AddrWidth)
    ) uBank (
        .clk, .rst_n, .sumValid, .sumAddr, .colSum0, .colSum1, .colSum2,
        .bankSel, .poolRdEn, .poolAddr, .poolDat
    );

    // frame events come from the raw item inputs
    frameCtrl uFrame (
        .clk, .rst_n, .actValid, .firstBlk, .bankSel, .poolEn
    );

endmodule

/* hw/psumPkg.sv */
//==========================================================
// array geometry of the psum block
// kernel column count is fixed in hardware, not a parameter
// the other values are defaults only; the top level copies
// them into module parameters and passes them down
//==========================================================

package psumPkg;

    // kernel columns, one dot product and one psum SRAM each
    localparam int NumCols = 3;

    // defaults for the top-level parameters
    localparam int DefDataWidth  = 8;
    localparam int DefBlockDepth = 4;
    localparam int DefLenPsum    = 4;
    localparam int DefPsumWidth  = 24;

    // address width for a square output map of side lenPsum
    // never below one bit, so a 1x1 map still has an address
    function automatic int addrWidthOf(int lenPsum);
        int width;
        width = $clog2(lenPsum * lenPsum);
        return (width < 1) ? 1 : width;
    endfunction

endpackage

/* hw/psumRam.sv */
//==========================================================
// SRAM model with one write port and one read port
// read data is registered and held while rdEn is low
// read and write of one address on one edge give old data
// the array has no reset: write a location before reading it
//==========================================================
`timescale 1ns/10ps

module psumRam #(
    parameter int AddrWidth = 4,
    parameter int DataWidth = 24
) (
    input  logic                 clk,
    input  logic                 wrEn,
    input  logic [AddrWidth-1:0] wrAddr,
    input  logic [DataWidth-1:0] wrData,
    input  logic                 rdEn,
    input  logic [AddrWidth-1:0] rdAddr,
    output logic [DataWidth-1:0] rdData
);

    // one word per output position
    logic [DataWidth-1:0] mem [2**AddrWidth];

    // write port
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // read port, output holds between reads
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

/* src.f */
hw/psumPkg.sv
hw/ctrlPkg.sv
hw/psumRam.sv
hw/dotStage.sv
hw/psumAccum.sv
hw/outputBank.sv
hw/frameCtrl.sv
hw/psumBlockTop.sv
test/tbChecker.sv
test/tbTop.sv

/* test/tbChecker.sv */
//==========================================================
// pool-side checker for the psum block testbench
// compares poolDat one cycle after each poolRdEn against
// the value that the driver placed on expDat with the read
// counts poolEn high cycles and checks them on testDone
// do not issue pool reads on two cycles in a row
//==========================================================
`timescale 1ns/10ps

module tbChecker #(
    parameter int PsumWidth = psumPkg::DefPsumWidth,
    parameter int AddrWidth = psumPkg::addrWidthOf(psumPkg::DefLenPsum)
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        poolRdEn,
    input  logic [AddrWidth-1:0]        poolAddr,
    input  logic signed [PsumWidth-1:0] poolDat,
    input  logic                        poolEn,
    input  logic signed [PsumWidth-1:0] expDat,
    input  int                          expPulses,
    input  int                          testId,
    input  logic                        testDone,
    input  logic                        runDone,
    output int                          errCount
);

    // read in flight, sampled with the request
    logic                        pending;
    logic signed [PsumWidth-1:0] pendExp;
    logic [AddrWidth-1:0]        pendAddr;
    logic                        readSeen;
    logic                        zeroBad;
    int                          pulseCount;
    int                          testChecks;
    int                          testErrs;
    int                          totalChecks;

    function automatic string testName(input int id);
        case (id)
            0:       return "resetFrame";
            1:       return "onlyItems";
            2:       return "multiBlockPingPong";
            default: return "weightReload";
        endcase
    endfunction

    initial begin
        errCount    = 0;
        totalChecks = 0;
        testChecks  = 0;
        testErrs    = 0;
        pending     = 1'b0;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending    = 1'b0;
            readSeen   = 1'b0;
            zeroBad    = 1'b0;
            pulseCount = 0;
        end else begin
            // data from the read one edge back
            if (pending) begin
                testChecks++;
                if (poolDat !== pendExp) begin
                    testErrs++;
                    $display("ERROR %s: addr %0d expected %0d, actual %0d",
                             testName(testId), pendAddr, pendExp, poolDat);
                end
            end
            // pool data must stay zero until the first read
            if (!readSeen) begin
                if (poolDat !== '0 && !zeroBad) begin
                    zeroBad = 1'b1;
                    testErrs++;
                    $display("ERROR %s: pool data before first read expected 0, actual %0d",
                             testName(testId), poolDat);
                end
                if (poolRdEn) begin
                    readSeen = 1'b1;
                    testChecks++;
                end
            end
            if (poolEn) begin
                pulseCount++;
            end
            pending  = poolRdEn;
            pendExp  = expDat;
            pendAddr = poolAddr;
            //======================================================
            // per-test and closing reports
            //======================================================
            if (testDone) begin
                testChecks++;
                if (pulseCount != expPulses) begin
                    testErrs++;
                    $display("ERROR %s: pool enable pulses expected %0d, actual %0d",
                             testName(testId), expPulses, pulseCount);
                end
                $display("test %s: %0d checks, %0d errors",
                         testName(testId), testChecks, testErrs);
                totalChecks += testChecks;
                errCount    += testErrs;
                testChecks   = 0;
                testErrs     = 0;
            end
            if (runDone) begin
                $display("total: %0d checks, %0d errors, %0d pool enable pulses",
                         totalChecks, errCount, pulseCount);
            end
        end
    end

endmodule

/* test/tbTop.sv */
//==========================================================
// testbench for the psum block
// random items from a 32-bit Fibonacci LFSR, fixed seed
// the model keeps column psums and both output banks
// reads of the previous frame run while the next one fills
// frames end with drained reads and 6 idle cycles
//==========================================================
`timescale 1ns/10ps

module tbTop;

    import psumPkg::*;

    localparam int DataWidth     = DefDataWidth;
    localparam int BlockDepth    = DefBlockDepth;
    localparam int PsumWidth     = DefPsumWidth;
    localparam int AddrWidth     = addrWidthOf(DefLenPsum);
    localparam int MapSize       = 2**AddrWidth;
    localparam logic [31:0] Seed = 32'h3f0e;
    localparam int ResetCycles   = 10;
    localparam int MultiFrames   = 4;
    localparam int ReloadFrames  = 2;
    localparam int GapIdle       = 6;
    localparam int PoolEnTimeout = 20;
    localparam int HalfRange     = 1 << (DataWidth-1);

    logic                                     clk;
    logic                                     rst_n;
    logic                                     weiLoad;
    logic [NumCols*BlockDepth*DataWidth-1:0]  wei;
    logic                                     actValid;
    logic [BlockDepth*DataWidth-1:0]          act;
    logic [AddrWidth-1:0]                     actAddr;
    logic                                     firstBlk;
    logic                                     lastBlk;
    logic                                     poolRdEn;
    logic [AddrWidth-1:0]                     poolAddr;
    logic                                     poolEn;
    logic signed [PsumWidth-1:0]              poolDat;
    logic signed [PsumWidth-1:0]              expDat;
    int                                       expPulses;
    int                                       testId;
    logic                                     testDone;
    logic                                     runDone;
    int                                       errCount;

    //==========================================================
    // reference model state
    //==========================================================
    logic [31:0] lfsrState;
    int          weiM [NumCols][BlockDepth];
    int          colMem [NumCols][MapSize];
    int          bankMem [2][MapSize];
    bit          bankWr [2][MapSize];
    // model copy of the write bank select
    bit          wrBank;
    bit          frameOpen;
    int          frameCount;
    int          readQ [$];

    psumBlockTop #(
        .DataWidth (DataWidth), .BlockDepth (BlockDepth),
        .PsumWidth (PsumWidth), .AddrWidth  (AddrWidth)
    ) uut (
        .clk, .rst_n, .weiLoad, .wei, .actValid, .act, .actAddr, .firstBlk, .lastBlk,
        .poolRdEn, .poolAddr, .poolEn, .poolDat
    );

    tbChecker #(
        .PsumWidth (PsumWidth),
        .AddrWidth (AddrWidth)
    ) uChk (
        .clk, .rst_n, .poolRdEn, .poolAddr, .poolDat, .poolEn, .expDat,
        .expPulses, .testId, .testDone, .runDone, .errCount
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken
    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = (v << 1) | lfsrState[0];
        end
        return v;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $finish;
    endtask

    // next edge, then drive; pool reads go out every other cycle
    task automatic stepClock();
        @(posedge clk);
        #1;
        actValid = 1'b0;
        if (poolRdEn) begin
            poolRdEn = 1'b0;
        end else if (readQ.size() > 0) begin
            poolAddr = readQ.pop_front();
            expDat   = PsumWidth'(bankMem[!wrBank][poolAddr]);
            poolRdEn = 1'b1;
        end
    endtask

    task automatic waitPoolEn();
        int waited;
        waited = 0;
        while (!poolEn && waited < PoolEnTimeout) begin
            stepClock();
            waited++;
        end
        if (!poolEn) begin
            abortRun($sformatf("pool enable never came after frame %0d started", frameCount));
        end
    endtask

    task automatic loadWeights();
        for (int c = 0; c < NumCols; c++) begin
            for (int k = 0; k < BlockDepth; k++) begin
                weiM[c][k] = randBits(DataWidth) - HalfRange;
                wei[(c*BlockDepth + k)*DataWidth +: DataWidth] = DataWidth'(weiM[c][k]);
            end
        end
        weiLoad = 1'b1;
        stepClock();
        weiLoad = 1'b0;
    endtask

    // queue the finished bank for reading, then swap banks
    task automatic startFrameModel();
        frameOpen = 1'b1;
        readQ.delete();
        for (int a = 0; a < MapSize; a++) begin
            if (bankWr[wrBank][a]) begin
                readQ.push_back(a);
            end
        end
        wrBank = !wrBank;
        for (int a = 0; a < MapSize; a++) begin
            bankWr[wrBank][a] = 1'b0;
        end
        frameCount++;
        if (frameCount > 1) begin
            expPulses++;
        end
    endtask

    task automatic sendItem(input int addr, input bit first, input bit last);
        int actVal [BlockDepth];
        int dot;
        int total;
        bit newFrame;
        newFrame = !frameOpen;
        if (newFrame) begin
            startFrameModel();
        end
        for (int k = 0; k < BlockDepth; k++) begin
            actVal[k] = randBits(DataWidth) - HalfRange;
            act[k*DataWidth +: DataWidth] = DataWidth'(actVal[k]);
        end
        // first block starts from zero, later blocks add on
        total = 0;
        for (int c = 0; c < NumCols; c++) begin
            dot = 0;
            for (int k = 0; k < BlockDepth; k++) begin
                dot += actVal[k] * weiM[c][k];
            end
            colMem[c][addr] = first ? dot : colMem[c][addr] + dot;
            total += colMem[c][addr];
        end
        if (last) begin
            bankMem[wrBank][addr] = total;
            bankWr[wrBank][addr]  = 1'b1;
        end
        actValid = 1'b1;
        actAddr  = addr;
        firstBlk = first;
        lastBlk  = last;
        stepClock();
        if (newFrame && frameCount > 1) begin
            waitPoolEn();
        end
    endtask

    // drain reads, then the idle gap that closes the frame
    task automatic endFrame();
        int guard;
        guard = 0;
        while ((readQ.size() > 0 || poolRdEn) && guard < 2*MapSize + 2) begin
            stepClock();
            guard++;
        end
        repeat (GapIdle) stepClock();
        frameOpen = 1'b0;
    endtask

    // one frame of nBlk blocks over 3 to 6 distinct addresses
    task automatic runFrame(input int nBlk);
        int addrs [$];
        bit used [MapSize];
        int a;
        int nAddr;
        nAddr = 3 + randBits(2);
        for (int i = 0; i < MapSize; i++) begin
            used[i] = 1'b0;
        end
        while (addrs.size() < nAddr) begin
            a = randBits(AddrWidth);
            if (!used[a]) begin
                used[a] = 1'b1;
                addrs.push_back(a);
            end
        end
        for (int b = 0; b < nBlk; b++) begin
            foreach (addrs[i]) begin
                sendItem(addrs[i], b == 0, b == nBlk-1);
                // back-to-back repeat hits the bypass path
                if (b > 0 && randBits(2) == 0) begin
                    sendItem(addrs[i], 1'b0, b == nBlk-1);
                end
            end
        end
        endFrame();
    endtask

    task automatic finishTest();
        testDone = 1'b1;
        stepClock();
        testDone = 1'b0;
    endtask

    //==========================================================
    // test sequence
    //==========================================================
    initial begin
        lfsrState  = Seed;
        rst_n      = 1'b0;
        weiLoad    = 1'b0;
        wei        = '0;
        actValid   = 1'b0;
        act        = '0;
        actAddr    = '0;
        firstBlk   = 1'b0;
        lastBlk    = 1'b0;
        poolRdEn   = 1'b0;
        poolAddr   = '0;
        expDat     = '0;
        expPulses  = 0;
        testId     = 0;
        testDone   = 1'b0;
        runDone    = 1'b0;
        wrBank     = 1'b0;
        frameOpen  = 1'b0;
        frameCount = 0;
        for (int a = 0; a < MapSize; a++) begin
            bankWr[0][a] = 1'b0;
            bankWr[1][a] = 1'b0;
        end
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        loadWeights();
        // first frame, no pulse expected
        runFrame(1);
        finishTest();
        testId = 1;
        runFrame(2 + randBits(1));
        finishTest();
        testId = 2;
        repeat (MultiFrames) runFrame(2 + randBits(1));
        finishTest();
        testId = 3;
        loadWeights();
        repeat (ReloadFrames) runFrame(2 + randBits(1));
        // short frame so the last bank gets read
        runFrame(1);
        finishTest();
        runDone = 1'b1;
        stepClock();
        runDone = 1'b0;
        if (errCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
